// ==== Makefile ====
# Verilator simulation of the viper core testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= viper_core_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+rtl
rtl/viper_pkg.sv
rtl/program_counter.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/sequencer.sv
rtl/viper_core.sv
tb/viper_core_checker.sv
tb/viper_core_tb.sv

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ns
`include "viper_defs.svh"

module execute_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  viper_pkg::word_t      instruction,
    input  viper_pkg::word_t      datai,
    input  logic                  capture_operand,
    input  logic                  execute,
    input  viper_pkg::word_t      source,
    input  viper_pkg::word_t      reg1,
    input  viper_pkg::word_t      reg2,
    input  viper_pkg::word_t      pc,
    output logic                  needs_memory,
    output logic                  store,
    output viper_pkg::addr_t      operand_addr,
    output viper_pkg::word_t      store_data,
    output viper_pkg::reg_index_t read_index,
    output logic                  write_enable,
    output viper_pkg::reg_index_t write_index,
    output viper_pkg::word_t      write_data,
    output logic                  pc_load,
    output viper_pkg::word_t      pc_data
);

    viper_pkg::operand_mode_t    mode;
    logic [2:0]                  dest;
    logic                        compare;
    logic [3:0]                  func;
    viper_pkg::addr_t            tail;
    viper_pkg::word_t            operand;
    logic [`VIPER_RESULT_W-1:0]  sum;
    logic [`VIPER_RESULT_W-1:0]  difference;
    viper_pkg::word_t            result;
    logic                        func_writes;
    logic                        push;
    viper_pkg::reg_index_t       dest_index;
    logic                        dest_ok;
    logic                        reg_op;
    logic                        less;
    logic                        equal;
    logic                        relation;
    logic                        flag;

    assign mode    = viper_pkg::operand_mode_t'(instruction[`VIPER_MF_LSB +: 2]);
    assign dest    = instruction[`VIPER_DF_LSB +: 3];
    assign compare = instruction[`VIPER_CF_BIT];
    assign func    = instruction[`VIPER_FF_LSB +: 4];
    assign tail    = instruction[`VIPER_ADDR_W-1:0];

    assign read_index   = instruction[`VIPER_SEL_LSB +: 2];
    assign needs_memory = mode != viper_pkg::IMMEDIATE;
    assign store        = !compare && (dest == 3'(`VIPER_DF_STORE));
    assign store_data   = source;

    // operand reads and stores use the same address, wrapped at 2^20
    always_comb begin
        case (mode)
            viper_pkg::INDEXED_R1: operand_addr = tail + viper_pkg::addr_t'(reg1);
            viper_pkg::INDEXED_R2: operand_addr = tail + viper_pkg::addr_t'(reg2);
            default: operand_addr = tail;
        endcase
    end

    always_ff @(posedge clock) begin
        if (capture_operand) begin
            operand <= (mode == viper_pkg::IMMEDIATE) ? viper_pkg::word_t'(tail) : datai;
        end
    end

    assign less  = $signed(source) < $signed(operand);
    assign equal = source == operand;

    // codes 6 and 7 fall into the default but never reach the flag
    always_comb begin
        case (func[2:0])
            3'd0: relation = less;
            3'd1: relation = !less;
            3'd2: relation = equal;
            3'd3: relation = !equal;
            3'd4: relation = less || equal;
            default: relation = !(less || equal);
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flag <= 1'b0;
        end else if (execute && compare && func[2:1] != 2'b11) begin
            // the upper half of the codes accumulates into the old flag
            flag <= relation || (func[3] && flag);
        end
    end

    assign sum        = source[`VIPER_RESULT_W-1:0] + operand[`VIPER_RESULT_W-1:0];
    assign difference = source[`VIPER_RESULT_W-1:0] - operand[`VIPER_RESULT_W-1:0];

    always_comb begin
        result      = '0;
        func_writes = 1'b1;
        case (func)
            4'd0: result = '0 - operand;
            4'd2, 4'd3: result = operand;
            4'd4, 4'd5, 4'd8, 4'd10: result = viper_pkg::word_t'(sum);
            4'd6, 4'd7, 4'd9, 4'd11: result = viper_pkg::word_t'(difference);
            4'd12: begin
                if (mode == viper_pkg::IMMEDIATE || mode == viper_pkg::DIRECT) begin
                    result = source >> 1;
                end else begin
                    result = viper_pkg::word_t'({source[`VIPER_RESULT_W-2:0], 1'b0});
                end
            end
            default: func_writes = 1'b0;
        endcase
    end

    // codes 4 and 5 write the pc only when the flag agrees, 6 writes nothing
    always_comb begin
        dest_index = dest[1:0];
        dest_ok    = !dest[2];
        if (dest == 3'd4) begin
            dest_index = 2'd3;
            dest_ok    = flag;
        end else if (dest == 3'd5) begin
            dest_index = 2'd3;
            dest_ok    = !flag;
        end
    end

    // push saves the advanced pc in register 2 whatever the destination says
    assign push   = func == 4'd1;
    assign reg_op = execute && !compare && !store;

    assign write_enable = reg_op && (push || (func_writes && dest_ok));
    assign write_index  = push ? 2'd2 : dest_index;
    assign write_data   = push ? pc : result;
    assign pc_load      = reg_op && (push || (func_writes && dest_ok && dest_index == 2'd3));
    assign pc_data      = push ? operand : result;

endmodule

// ==== rtl/program_counter.sv ====
`timescale 1ns/1ns
`include "viper_defs.svh"

module program_counter (
    input  logic             clock,
    input  logic             reset,
    input  logic             advance,
    input  logic             load,
    input  viper_pkg::word_t load_value,
    output viper_pkg::word_t pc
);

    viper_pkg::word_t next_step;

    // the step drops the high bits first, so the pc never grows past 2^29 + 8
    assign next_step = viper_pkg::word_t'(pc[`VIPER_PC_W-1:0])
                     + viper_pkg::word_t'(`VIPER_PC_STEP);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (load) begin
            // a load in EXECUTE overrides the advance made at the end of FETCH
            pc <= load_value;
        end else if (advance) begin
            pc <= next_step;
        end
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic                  clock,
    input  logic                  reset,
    input  viper_pkg::reg_index_t read_index,
    input  viper_pkg::word_t      read_pc,
    output viper_pkg::word_t      read_data,
    input  logic                  write_enable,
    input  viper_pkg::reg_index_t write_index,
    input  viper_pkg::word_t      write_data,
    output viper_pkg::word_t      reg1,
    output viper_pkg::word_t      reg2
);

    viper_pkg::word_t reg0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            reg0 <= '0;
            reg1 <= '0;
            reg2 <= '0;
        end else if (write_enable) begin
            case (write_index)
                2'd0: begin
                    reg0 <= write_data;
                end
                2'd1: begin
                    reg1 <= write_data;
                end
                2'd2: begin
                    reg2 <= write_data;
                end
                default: begin
                    // index 3 goes to the program counter instead
                end
            endcase
        end
    end

    always_comb begin
        case (read_index)
            2'd0: read_data = reg0;
            2'd1: read_data = reg1;
            2'd2: read_data = reg2;
            default: read_data = read_pc;
        endcase
    end

endmodule

// ==== rtl/sequencer.sv ====
`timescale 1ns/1ns

module sequencer (
    input  logic             clock,
    input  logic             reset,
    input  viper_pkg::word_t datai,
    input  viper_pkg::word_t pc,
    input  logic             needs_memory,
    input  logic             store,
    input  viper_pkg::addr_t operand_addr,
    input  viper_pkg::word_t store_data,
    output viper_pkg::word_t instruction,
    output logic             capture_instruction,
    output logic             capture_operand,
    output logic             execute,
    output viper_pkg::addr_t addr,
    output viper_pkg::word_t datao,
    output logic             rd,
    output logic             wr
);

    viper_pkg::state_t state;

    // low during reset and for the first edge after it, so the bus stays idle
    logic running;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running     <= 1'b0;
            state       <= viper_pkg::FETCH;
            instruction <= '0;
        end else begin
            running <= 1'b1;
            case (state)
                viper_pkg::FETCH: begin
                    if (capture_instruction) begin
                        instruction <= datai;
                        state       <= viper_pkg::OPERAND;
                    end
                end
                viper_pkg::OPERAND: begin
                    state <= viper_pkg::EXECUTE;
                end
                default: begin
                    state <= viper_pkg::FETCH;
                end
            endcase
        end
    end

    assign capture_instruction = running && (state == viper_pkg::FETCH);
    assign capture_operand     = state == viper_pkg::OPERAND;
    assign execute             = state == viper_pkg::EXECUTE;

    // a store takes its address in EXECUTE, so its OPERAND cycle reads nothing
    assign rd = capture_instruction || (capture_operand && needs_memory && !store);
    assign wr = execute && store;

    assign addr  = (state == viper_pkg::FETCH) ? viper_pkg::addr_t'(pc) : operand_addr;
    assign datao = store_data;

endmodule

// ==== rtl/viper_core.sv ====
`timescale 1ns/1ns

module viper_core (
    input  logic             clock,
    input  logic             reset,
    input  viper_pkg::word_t datai,
    output viper_pkg::addr_t addr,
    output viper_pkg::word_t datao,
    output logic             rd,
    output logic             wr
);

    viper_pkg::word_t      instruction;
    logic                  capture_instruction;
    logic                  capture_operand;
    logic                  execute;
    viper_pkg::word_t      pc;
    logic                  needs_memory;
    logic                  store;
    viper_pkg::addr_t      operand_addr;
    viper_pkg::word_t      store_data;
    viper_pkg::reg_index_t read_index;
    viper_pkg::word_t      source;
    viper_pkg::word_t      reg1;
    viper_pkg::word_t      reg2;
    logic                  write_enable;
    viper_pkg::reg_index_t write_index;
    viper_pkg::word_t      write_data;
    logic                  pc_load;
    viper_pkg::word_t      pc_data;

    sequencer i_sequencer (
        .clock               (clock),
        .reset               (reset),
        .datai               (datai),
        .pc                  (pc),
        .needs_memory        (needs_memory),
        .store               (store),
        .operand_addr        (operand_addr),
        .store_data          (store_data),
        .instruction         (instruction),
        .capture_instruction (capture_instruction),
        .capture_operand     (capture_operand),
        .execute             (execute),
        .addr                (addr),
        .datao               (datao),
        .rd                  (rd),
        .wr                  (wr)
    );

    // register 3 of the machine
    program_counter i_program_counter (
        .clock      (clock),
        .reset      (reset),
        .advance    (capture_instruction),
        .load       (pc_load),
        .load_value (pc_data),
        .pc         (pc)
    );

    register_file i_register_file (
        .clock        (clock),
        .reset        (reset),
        .read_index   (read_index),
        .read_pc      (pc),
        .read_data    (source),
        .write_enable (write_enable),
        .write_index  (write_index),
        .write_data   (write_data),
        .reg1         (reg1),
        .reg2         (reg2)
    );

    execute_unit i_execute_unit (
        .clock           (clock),
        .reset           (reset),
        .instruction     (instruction),
        .datai           (datai),
        .capture_operand (capture_operand),
        .execute         (execute),
        .source          (source),
        .reg1            (reg1),
        .reg2            (reg2),
        .pc              (pc),
        .needs_memory    (needs_memory),
        .store           (store),
        .operand_addr    (operand_addr),
        .store_data      (store_data),
        .read_index      (read_index),
        .write_enable    (write_enable),
        .write_index     (write_index),
        .write_data      (write_data),
        .pc_load         (pc_load),
        .pc_data         (pc_data)
    );

endmodule

// ==== rtl/viper_defs.svh ====
`ifndef VIPER_DEFS_SVH
`define VIPER_DEFS_SVH

// data path and bus widths
`define VIPER_WORD_W 32
`define VIPER_ADDR_W 20

// add and subtract keep only the low bits of their result
`define VIPER_RESULT_W 30

// the program counter wraps its low bits before every step
`define VIPER_PC_W 29
`define VIPER_PC_STEP 8

// instruction word layout, low bit of each field
// the two-bit source register select
`define VIPER_SEL_LSB 29

// the two-bit operand mode
`define VIPER_MF_LSB 27

// the three-bit destination code
`define VIPER_DF_LSB 24

// a set compare bit turns the word into a flag update
`define VIPER_CF_BIT 23

// the four-bit function shares its low bit with the top of the tail
`define VIPER_FF_LSB 19

// destination code that turns a register operation into a store
`define VIPER_DF_STORE 7

`endif

// ==== rtl/viper_pkg.sv ====
`include "viper_defs.svh"

package viper_pkg;

    typedef logic [`VIPER_WORD_W-1:0] word_t;
    typedef logic [`VIPER_ADDR_W-1:0] addr_t;

    // registers 0 to 2 live in the register file, register 3 is the pc
    typedef logic [1:0] reg_index_t;

    // every instruction walks through all three states once
    typedef enum logic [1:0] {
        FETCH,
        OPERAND,
        EXECUTE
    } state_t;

    // where the operand comes from
    typedef enum logic [1:0] {
        IMMEDIATE,
        DIRECT,
        INDEXED_R1,
        INDEXED_R2
    } operand_mode_t;

endpackage

// ==== tb/viper_core_checker.sv ====
`timescale 1ns/1ns

module viper_core_checker (
    input logic              clock,
    input logic              reset,
    input viper_pkg::state_t state,
    input logic              rd,
    input logic              wr
);

    // the bus never reads and writes in the same cycle
    read_write_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(rd && wr)
    ) else $error("rd and wr are high in the same cycle");

    // a store only drives the bus in EXECUTE
    write_in_execute: assert property (
        @(posedge clock) disable iff (reset) wr |-> state == viper_pkg::EXECUTE
    ) else $error("wr is high outside EXECUTE");

endmodule

// ==== tb/viper_core_tb.sv ====
`timescale 1ns/1ns
`include "viper_defs.svh"

module viper_core_tb;

    localparam int NUM_INSTRUCTIONS = 2000;
    localparam int RESET_CYCLES     = 10;
    localparam int START_TIMEOUT    = 8;
    localparam int DRIVE_DELAY      = 5;
    localparam viper_pkg::word_t RESULT_MASK = (32'd1 << `VIPER_RESULT_W) - 32'd1;

    logic             clock;
    logic             reset;
    viper_pkg::word_t datai;
    viper_pkg::addr_t addr;
    viper_pkg::word_t datao;
    logic             rd;
    logic             wr;

    integer seed = 60;

    // sparse memory, a word never written is random on its first read
    viper_pkg::word_t mem [viper_pkg::addr_t];

    // reference model of the machine
    viper_pkg::word_t m_reg [3];
    viper_pkg::word_t m_pc;
    logic             m_flag;

    viper_core i_viper_core (
        .clock (clock),
        .reset (reset),
        .datai (datai),
        .addr  (addr),
        .datao (datao),
        .rd    (rd),
        .wr    (wr)
    );

    bind sequencer viper_core_checker i_viper_core_checker (
        .clock (clock),
        .reset (reset),
        .state (state),
        .rd    (rd),
        .wr    (wr)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic viper_pkg::word_t read_memory(input viper_pkg::addr_t a);
        if (!mem.exists(a)) begin
            mem[a] = $random(seed);
        end
        return mem[a];
    endfunction

    // signed compare by function code, codes 6 and 7 never get here
    function automatic logic compare_relation(input logic [2:0] code,
                                              input viper_pkg::word_t a,
                                              input viper_pkg::word_t b);
        int signed sa;
        int signed sb;
        sa = $signed(a);
        sb = $signed(b);
        case (code)
            3'd0: return sa < sb;
            3'd1: return sa >= sb;
            3'd2: return sa == sb;
            3'd3: return sa != sb;
            3'd4: return sa <= sb;
            3'd5: return sa > sb;
            default: return 1'b0;
        endcase
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input viper_pkg::word_t expected,
                                   input viper_pkg::word_t actual);
        $display("Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        stop_run();
    endtask

    task automatic check_word(input string name, input viper_pkg::word_t expected,
                              input viper_pkg::word_t actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    task automatic check_strobes(input logic exp_rd, input logic exp_wr);
        check_word("rd", viper_pkg::word_t'(exp_rd), viper_pkg::word_t'(rd));
        check_word("wr", viper_pkg::word_t'(exp_wr), viper_pkg::word_t'(wr));
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic wait_for_first_fetch();
        int cycles;
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (rd !== 1'b1 && cycles < START_TIMEOUT);
        assert (rd === 1'b1) else begin
            $display("Timeout: the core did not fetch within %0d cycles of reset", cycles);
            stop_run();
        end
        check_word("first fetch cycle", 32'd1, viper_pkg::word_t'(cycles));
    endtask

    task automatic run_instruction();
        viper_pkg::word_t word;
        viper_pkg::word_t operand;
        viper_pkg::word_t source;
        viper_pkg::word_t result;
        viper_pkg::addr_t tail;
        viper_pkg::addr_t eff;
        logic [1:0]       sel;
        logic [1:0]       mode;
        logic [2:0]       dest;
        logic             compare;
        logic [3:0]       func;
        logic             is_store;
        logic             reads;
        logic             writes;
        logic [1:0]       target;
        logic             target_ok;

        check_strobes(1'b1, 1'b0);
        check_word("addr", viper_pkg::word_t'(m_pc[`VIPER_ADDR_W-1:0]), viper_pkg::word_t'(addr));
        word  = read_memory(m_pc[`VIPER_ADDR_W-1:0]);
        datai = word;
        next_cycle();
        m_pc = viper_pkg::word_t'(m_pc[`VIPER_PC_W-1:0]) + viper_pkg::word_t'(`VIPER_PC_STEP);

        sel      = word[`VIPER_SEL_LSB +: 2];
        mode     = word[`VIPER_MF_LSB +: 2];
        dest     = word[`VIPER_DF_LSB +: 3];
        compare  = word[`VIPER_CF_BIT];
        func     = word[`VIPER_FF_LSB +: 4];
        tail     = word[`VIPER_ADDR_W-1:0];
        is_store = !compare && dest == 3'(`VIPER_DF_STORE);
        reads    = mode != 2'd0 && !is_store;
        case (mode)
            2'd2: eff = tail + viper_pkg::addr_t'(m_reg[1]);
            2'd3: eff = tail + viper_pkg::addr_t'(m_reg[2]);
            default: eff = tail;
        endcase

        check_strobes(reads, 1'b0);
        operand = viper_pkg::word_t'(tail);
        datai   = '0;
        if (reads) begin
            check_word("addr", viper_pkg::word_t'(eff), viper_pkg::word_t'(addr));
            operand = read_memory(eff);
            datai   = operand;
        end
        next_cycle();

        source = (sel == 2'd3) ? m_pc : m_reg[sel];
        datai  = '0;
        if (is_store) begin
            check_strobes(1'b0, 1'b1);
            check_word("addr", viper_pkg::word_t'(eff), viper_pkg::word_t'(addr));
            check_word("datao", source, datao);
            mem[eff] = source;
        end else begin
            check_strobes(1'b0, 1'b0);
        end

        if (compare) begin
            if (func[2:0] < 3'd6) begin
                m_flag = compare_relation(func[2:0], source, operand) || (func[3] && m_flag);
            end
        end else if (!is_store && func == 4'd1) begin
            m_reg[2] = m_pc;
            m_pc     = operand;
        end else if (!is_store) begin
            writes = 1'b1;
            result = '0;
            case (func)
                4'd0: result = -operand;
                4'd2, 4'd3: result = operand;
                4'd4, 4'd5, 4'd8, 4'd10: result = (source + operand) & RESULT_MASK;
                4'd6, 4'd7, 4'd9, 4'd11: result = (source - operand) & RESULT_MASK;
                4'd12: begin
                    if (!mode[1]) begin
                        result = source >> 1;
                    end else begin
                        result = viper_pkg::word_t'(source[`VIPER_PC_W-1:0]) << 1;
                    end
                end
                default: writes = 1'b0;
            endcase
            target    = dest[1:0];
            target_ok = 1'b1;
            if (dest == 3'd4) begin
                target    = 2'd3;
                target_ok = m_flag;
            end else if (dest == 3'd5) begin
                target    = 2'd3;
                target_ok = !m_flag;
            end else if (dest == 3'd6) begin
                target_ok = 1'b0;
            end
            if (writes && target_ok) begin
                if (target == 2'd3) begin
                    m_pc = result;
                end else begin
                    m_reg[target] = result;
                end
            end
        end
        next_cycle();
    endtask

    initial begin
        reset    = 1'b1;
        datai    = '0;
        m_reg[0] = '0;
        m_reg[1] = '0;
        m_reg[2] = '0;
        m_pc     = '0;
        m_flag   = 1'b0;
        repeat (RESET_CYCLES) begin
            next_cycle();
            check_strobes(1'b0, 1'b0);
        end
        reset = 1'b0;
        #1;
        check_strobes(1'b0, 1'b0);
        wait_for_first_fetch();
        for (int i = 0; i < NUM_INSTRUCTIONS; i++) begin
            run_instruction();
        end
        $display("All tests passed");
        $finish;
    end

endmodule
